/* n64_dl_pkg.sv */
package n64_dl_pkg;

	// ========================================
	// Download index codes
	// ========================================

	// Compared against the low six bits of the host index
	localparam logic [5:0] DL_IDX_PIF = 6'd0;
	localparam logic [5:0] DL_IDX_N64 = 6'd1;
	localparam logic [5:0] DL_IDX_GB  = 6'd2;

	// ========================================
	// Memory map and sizes
	// ========================================

	localparam int MEM_ADDR_W = 27;

	// Handheld cartridge image lives above the main ROM area
	localparam logic [MEM_ADDR_W-1:0] CARTGB_START = 27'd8388608;

	// Word address bits decoded by the on-chip RAM model
	localparam int RAM_WORD_BITS = 10;
	localparam int RAM_LATENCY   = 2;

	localparam int PIF_ADDR_W = 10;
	localparam int AR_W       = 12;

	// ========================================
	// Assembled download word
	// ========================================

	// Boot ROM fills it bytewise, handheld cart fills it by halfword
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} dl_word_t;

endpackage

/* download_router.sv */
`timescale 1ns/1ns

module download_router (
	input  logic                              clk_1x,
	input  logic                              RESET,
	input  logic                              ioctl_download,
	input  logic [7:0]                        ioctl_index,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] ioctl_addr,
	output logic                              pif_active,
	output logic                              n64_active,
	output logic                              gb_active,
	output logic                              romcopy_start,
	output logic [n64_dl_pkg::MEM_ADDR_W-1:0] romcopy_size,
	output logic                              cart_loaded
);

	logic ioctl_download_1;
	logic n64_dl_end;

	// Download just dropped while the main cart index is selected
	assign n64_dl_end = !ioctl_download && ioctl_download_1 &&
		(ioctl_index[5:0] == n64_dl_pkg::DL_IDX_N64);

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_active       <= 1'b0;
			n64_active       <= 1'b0;
			gb_active        <= 1'b0;
			ioctl_download_1 <= 1'b0;
			romcopy_start    <= 1'b0;
			cart_loaded      <= 1'b0;
		end else begin
			pif_active <= ioctl_download && (ioctl_index[5:0] == n64_dl_pkg::DL_IDX_PIF);
			n64_active <= ioctl_download && (ioctl_index[5:0] == n64_dl_pkg::DL_IDX_N64);
			gb_active  <= ioctl_download && (ioctl_index[5:0] == n64_dl_pkg::DL_IDX_GB);

			ioctl_download_1 <= ioctl_download;
			romcopy_start    <= n64_dl_end;

			// Sticky until next reset
			if (n64_active) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// Last address of the image gives the copy size
	always_ff @(posedge clk_1x) begin
		if (n64_dl_end) begin
			romcopy_size <= ioctl_addr;
		end
	end

endmodule

/* pifrom_packer.sv */
`timescale 1ns/1ns

module pifrom_packer (
	input  logic                              clk_1x,
	input  logic                              RESET,
	input  logic                              pif_active,
	input  logic                              ioctl_wr,
	input  logic [7:0]                        ioctl_index,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	output logic [n64_dl_pkg::PIF_ADDR_W-1:0] pifrom_wraddress,
	output logic [31:0]                       pifrom_wrdata,
	output logic                              pifrom_wren
);

	n64_dl_pkg::dl_word_t word_q;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pifrom_wren <= 1'b0;
		end else begin
			// Second half completes the word
			pifrom_wren <= pif_active && ioctl_wr && ioctl_addr[1];
		end
	end

	// Bytes swapped inside each beat
	always_ff @(posedge clk_1x) begin
		if (pif_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				word_q.bytes[3]  <= ioctl_dout[7:0];
				word_q.bytes[2]  <= ioctl_dout[15:8];
				pifrom_wraddress <= {ioctl_index[6], ioctl_addr[10:2]};
			end else begin
				word_q.bytes[1] <= ioctl_dout[7:0];
				word_q.bytes[0] <= ioctl_dout[15:8];
			end
		end
	end

	assign pifrom_wrdata = word_q.bytes;

endmodule

/* cart_writer.sv */
`timescale 1ns/1ns

module cart_writer (
	input  logic                              clk_1x,
	input  logic                              RESET,
	input  logic                              gb_active,
	input  logic                              ioctl_wr,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	input  logic                              cart_ready,
	output logic                              cart_req,
	output logic [n64_dl_pkg::MEM_ADDR_W-1:0] cart_addr,
	output logic [31:0]                       cart_wdata,
	output logic                              ioctl_wait
);

	n64_dl_pkg::dl_word_t word_q;
	logic                 word_done;

	assign word_done = gb_active && ioctl_wr && ioctl_addr[1];

	// ========================================
	// Request and host stall
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			cart_req   <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			cart_req <= word_done;
			if (!gb_active) begin
				ioctl_wait <= 1'b0;
			end else begin
				if (word_done) begin
					ioctl_wait <= 1'b1;
				end
				// Memory took the word, let the host continue
				if (cart_ready) begin
					ioctl_wait <= 1'b0;
				end
			end
		end
	end

	// ========================================
	// Word assembly
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (gb_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				word_q.halves[0] <= ioctl_dout;
				cart_addr        <= ioctl_addr + n64_dl_pkg::CARTGB_START;
			end else begin
				word_q.halves[1] <= ioctl_dout;
			end
		end
	end

	assign cart_wdata = word_q.halves;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
	input  logic                              clk_1x,
	input  logic                              RESET,
	input  logic                              sys_req,
	input  logic                              sys_rnw,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] sys_addr,
	input  logic [3:0]                        sys_be,
	input  logic [31:0]                       sys_wdata,
	output logic                              sys_ready,
	output logic [31:0]                       sys_rdata,
	input  logic                              cart_req,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] cart_addr,
	input  logic [31:0]                       cart_wdata,
	output logic                              cart_ready,
	output logic                              mem_req,
	output logic                              mem_rnw,
	output logic [n64_dl_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [3:0]                        mem_be,
	output logic [31:0]                       mem_wdata,
	input  logic                              mem_ready,
	input  logic [31:0]                       mem_rdata
);

	logic                              sys_pend;
	logic                              cart_pend;
	logic                              busy;
	// High while the cartridge port owns the memory
	logic                              owner;
	logic                              sys_rnw_q;
	logic [n64_dl_pkg::MEM_ADDR_W-1:0] sys_addr_q;
	logic [3:0]                        sys_be_q;
	logic [31:0]                       sys_wdata_q;
	logic [n64_dl_pkg::MEM_ADDR_W-1:0] cart_addr_q;
	logic [31:0]                       cart_wdata_q;

	// ========================================
	// Pending requests and grant
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			sys_pend  <= 1'b0;
			cart_pend <= 1'b0;
			busy      <= 1'b0;
			owner     <= 1'b0;
			mem_req   <= 1'b0;
		end else begin
			mem_req <= 1'b0;
			if (sys_req) begin
				sys_pend <= 1'b1;
			end
			if (cart_req) begin
				cart_pend <= 1'b1;
			end

			if (busy) begin
				if (mem_ready) begin
					busy <= 1'b0;
				end
			end else if (sys_pend) begin
				// System side wins a tie
				busy     <= 1'b1;
				owner    <= 1'b0;
				sys_pend <= 1'b0;
				mem_req  <= 1'b1;
			end else if (cart_pend) begin
				busy      <= 1'b1;
				owner     <= 1'b1;
				cart_pend <= 1'b0;
				mem_req   <= 1'b1;
			end
		end
	end

	// Request fields captured with each pulse
	always_ff @(posedge clk_1x) begin
		if (sys_req) begin
			sys_rnw_q   <= sys_rnw;
			sys_addr_q  <= sys_addr;
			sys_be_q    <= sys_be;
			sys_wdata_q <= sys_wdata;
		end
		if (cart_req) begin
			cart_addr_q  <= cart_addr;
			cart_wdata_q <= cart_wdata;
		end
	end

	// ========================================
	// Memory side and ready steering
	// ========================================

	// Cart port only ever writes full words
	assign mem_rnw   = owner ? 1'b0 : sys_rnw_q;
	assign mem_addr  = owner ? cart_addr_q : sys_addr_q;
	assign mem_be    = owner ? 4'hF : sys_be_q;
	assign mem_wdata = owner ? cart_wdata_q : sys_wdata_q;

	assign sys_ready  = busy && mem_ready && !owner;
	assign cart_ready = busy && mem_ready && owner;
	assign sys_rdata  = mem_rdata;

endmodule

/* cart_ram.sv */
`timescale 1ns/1ns

module cart_ram (
	input  logic                              clk_1x,
	input  logic                              RESET,
	input  logic                              mem_req,
	input  logic                              mem_rnw,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] mem_addr,
	input  logic [3:0]                        mem_be,
	input  logic [31:0]                       mem_wdata,
	output logic                              mem_ready,
	output logic [31:0]                       mem_rdata
);

	localparam int WORDS = 2 ** n64_dl_pkg::RAM_WORD_BITS;

	logic [31:0]                            ram [0:WORDS-1];
	logic [n64_dl_pkg::RAM_LATENCY-1:0]     ready_sr;
	logic [n64_dl_pkg::RAM_WORD_BITS-1:0]   word_addr;

	// Upper address bits alias onto the same words
	assign word_addr = mem_addr[n64_dl_pkg::RAM_WORD_BITS+1:2];

	// Ready pulse delay line
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			ready_sr <= '0;
		end else begin
			ready_sr <= (ready_sr << 1) | mem_req;
		end
	end

	assign mem_ready = ready_sr[n64_dl_pkg::RAM_LATENCY-1];

	always_ff @(posedge clk_1x) begin
		if (mem_req) begin
			mem_rdata <= ram[word_addr];
			if (!mem_rnw) begin
				for (int i = 0; i < 4; i++) begin
					if (mem_be[i]) begin
						ram[word_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
					end
				end
			end
		end
	end

endmodule

/* aspect_ratio.sv */
`timescale 1ns/1ns

module aspect_ratio (
	input  logic                        clk_1x,
	input  logic                        RESET,
	input  logic                        pal,
	input  logic                        fixed_blanks_off,
	input  logic                        direct_fb,
	input  logic [1:0]                  crop_vertical,
	input  logic [1:0]                  ar_mode,
	output logic [n64_dl_pkg::AR_W-1:0] video_arx,
	output logic [n64_dl_pkg::AR_W-1:0] video_ary
);

	logic [n64_dl_pkg::AR_W-1:0] core_x;
	logic [n64_dl_pkg::AR_W-1:0] core_y;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= 12'd4;
			core_y <= 12'd3;
		end else if (fixed_blanks_off || direct_fb) begin
			// Full picture shown, plain 4:3
			core_x <= 12'd4;
			core_y <= 12'd3;
		end else if (pal) begin
			case (crop_vertical)
				2'd0: begin
					core_x <= 12'd512;
					core_y <= 12'd387;
				end
				2'd1: begin
					core_x <= 12'd1024;
					core_y <= 12'd731;
				end
				2'd2: begin
					core_x <= 12'd2048;
					core_y <= 12'd1419;
				end
				default: ;
			endcase
		end else begin
			// NTSC
			case (crop_vertical)
				2'd0: begin
					core_x <= 12'd512;
					core_y <= 12'd381;
				end
				2'd1: begin
					core_x <= 12'd1280;
					core_y <= 12'd889;
				end
				2'd2: begin
					core_x <= 12'd2560;
					core_y <= 12'd1714;
				end
				default: ;
			endcase
		end
	end

	// Non-zero mode passes a scaler selection code instead
	assign video_arx = (ar_mode == 2'd0) ? core_x :
		{{(n64_dl_pkg::AR_W-2){1'b0}}, ar_mode - 2'd1};
	assign video_ary = (ar_mode == 2'd0) ? core_y : '0;

endmodule

/* n64_dl_top.sv */
`timescale 1ns/1ns

module n64_dl_top (
	input  logic                              clk_1x,
	input  logic                              RESET,
	input  logic                              ioctl_download,
	input  logic [7:0]                        ioctl_index,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	input  logic                              ioctl_wr,
	output logic                              ioctl_wait,
	output logic [n64_dl_pkg::PIF_ADDR_W-1:0] pifrom_wraddress,
	output logic [31:0]                       pifrom_wrdata,
	output logic                              pifrom_wren,
	input  logic                              sys_req,
	input  logic                              sys_rnw,
	input  logic [n64_dl_pkg::MEM_ADDR_W-1:0] sys_addr,
	input  logic [3:0]                        sys_be,
	input  logic [31:0]                       sys_wdata,
	output logic                              sys_ready,
	output logic [31:0]                       sys_rdata,
	output logic                              romcopy_start,
	output logic [n64_dl_pkg::MEM_ADDR_W-1:0] romcopy_size,
	output logic                              cart_loaded,
	input  logic                              pal,
	input  logic                              fixed_blanks_off,
	input  logic                              direct_fb,
	input  logic [1:0]                        crop_vertical,
	input  logic [1:0]                        ar_mode,
	output logic [n64_dl_pkg::AR_W-1:0]       video_arx,
	output logic [n64_dl_pkg::AR_W-1:0]       video_ary
);

	logic                              pif_active;
	logic                              n64_active;
	logic                              gb_active;
	logic                              cart_req;
	logic [n64_dl_pkg::MEM_ADDR_W-1:0] cart_addr;
	logic [31:0]                       cart_wdata;
	logic                              cart_ready;
	logic                              mem_req;
	logic                              mem_rnw;
	logic [n64_dl_pkg::MEM_ADDR_W-1:0] mem_addr;
	logic [3:0]                        mem_be;
	logic [31:0]                       mem_wdata;
	logic                              mem_ready;
	logic [31:0]                       mem_rdata;

	// ========================================
	// Download side
	// ========================================

	download_router u_router (
		.clk_1x, .RESET, .ioctl_download, .ioctl_index, .ioctl_addr,
		.pif_active, .n64_active, .gb_active,
		.romcopy_start, .romcopy_size, .cart_loaded
	);

	pifrom_packer u_pifrom (
		.clk_1x, .RESET, .pif_active, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.pifrom_wraddress, .pifrom_wrdata, .pifrom_wren
	);

	cart_writer u_cart_writer (
		.clk_1x, .RESET, .gb_active, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.cart_ready, .cart_req, .cart_addr, .cart_wdata, .ioctl_wait
	);

	// ========================================
	// Shared cartridge memory
	// ========================================

	mem_arbiter u_arbiter (
		.clk_1x, .RESET,
		.sys_req, .sys_rnw, .sys_addr, .sys_be, .sys_wdata, .sys_ready, .sys_rdata,
		.cart_req, .cart_addr, .cart_wdata, .cart_ready,
		.mem_req, .mem_rnw, .mem_addr, .mem_be, .mem_wdata, .mem_ready, .mem_rdata
	);

	cart_ram u_ram (
		.clk_1x, .RESET, .mem_req, .mem_rnw, .mem_addr, .mem_be, .mem_wdata,
		.mem_ready, .mem_rdata
	);

	aspect_ratio u_aspect (
		.clk_1x, .RESET, .pal, .fixed_blanks_off, .direct_fb, .crop_vertical, .ar_mode,
		.video_arx, .video_ary
	);

endmodule

/* tb_n64_dl.sv */
`timescale 1ns/1ns

module tb_n64_dl;

	localparam logic [26:0] CART_BASE = 27'd8388608;
	localparam int          TIMEOUT   = 40;

	localparam int OP_PIF     = 0;
	localparam int OP_GB      = 1;
	localparam int OP_SYS_WR  = 2;
	localparam int OP_SYS_RD  = 3;
	localparam int OP_PAIR    = 4;
	localparam int OP_ROMCOPY = 5;
	localparam int OP_ASPECT  = 6;

	logic        clk_1x;
	logic        RESET;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	logic [9:0]  pifrom_wraddress;
	logic [31:0] pifrom_wrdata;
	logic        pifrom_wren;
	logic        sys_req;
	logic        sys_rnw;
	logic [26:0] sys_addr;
	logic [3:0]  sys_be;
	logic [31:0] sys_wdata;
	logic        sys_ready;
	logic [31:0] sys_rdata;
	logic        romcopy_start;
	logic [26:0] romcopy_size;
	logic        cart_loaded;
	logic        pal;
	logic        fixed_blanks_off;
	logic        direct_fb;
	logic [1:0]  crop_vertical;
	logic [1:0]  ar_mode;
	logic [11:0] video_arx;
	logic [11:0] video_ary;

	// Reference model state
	logic [31:0] ref_mem [0:1023];
	logic [11:0] core_x;
	logic [11:0] core_y;
	int          error_count;

	// Operation table
	int          op_kind  [$];
	string       op_name  [$];
	logic [7:0]  op_index [$];
	logic [26:0] op_addr  [$];
	logic [26:0] op_addr2 [$];
	logic [31:0] op_data  [$];
	logic [31:0] op_data2 [$];
	logic [3:0]  op_be    [$];
	logic [6:0]  op_set   [$];

	n64_dl_top UUT (.*);

	initial begin
		clk_1x = 1'b0;
		forever begin
			#2 clk_1x = ~clk_1x;
		end
	end

	// ========================================
	// Checking helpers
	// ========================================

	task automatic stop_on_error(string why);
		error_count++;
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	// Word aligned address with random upper bits
	function automatic logic [26:0] make_addr(logic [9:0] word_idx);
		logic [14:0] upper;
		upper = 15'($urandom);
		return {upper, word_idx, 2'b00};
	endfunction

	task automatic ref_write(logic [26:0] addr, logic [3:0] be, logic [31:0] data);
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				ref_mem[addr[11:2]][8*i +: 8] = data[8*i +: 8];
			end
		end
	endtask

	task automatic add_op(int kind, string name, logic [7:0] idx, logic [26:0] addr,
		logic [26:0] addr2, logic [31:0] data, logic [31:0] data2, logic [3:0] be,
		logic [6:0] set);
		op_kind.push_back(kind);
		op_name.push_back(name);
		op_index.push_back(idx);
		op_addr.push_back(addr);
		op_addr2.push_back(addr2);
		op_data.push_back(data);
		op_data2.push_back(data2);
		op_be.push_back(be);
		op_set.push_back(set);
	endtask

	// ========================================
	// Host download side
	// ========================================

	task automatic send_beat(string name, logic [26:0] addr, logic [15:0] data);
		int cyc;
		cyc = 0;
		@(negedge clk_1x);
		// Host must not write while stalled
		while (ioctl_wait) begin
			cyc++;
			if (cyc > TIMEOUT) begin
				stop_on_error({"Timeout: ioctl_wait stuck high before a beat in ", name});
			end
			@(negedge clk_1x);
		end
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
	endtask

	task automatic wait_host_release(string name);
		int cyc;
		cyc = 0;
		@(negedge clk_1x);
		while (ioctl_wait) begin
			cyc++;
			if (cyc > TIMEOUT) begin
				stop_on_error({"Timeout: ioctl_wait never dropped in ", name});
			end
			@(negedge clk_1x);
		end
	endtask

	task automatic pack_pif_word(string name, logic [7:0] idx, logic [26:0] addr,
		logic [31:0] data);
		int cyc;
		cyc = 0;
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= idx;
		send_beat(name, addr, data[15:0]);
		send_beat(name, addr | 27'd2, data[31:16]);
		@(negedge clk_1x);
		while (!pifrom_wren) begin
			cyc++;
			if (cyc > TIMEOUT) begin
				stop_on_error({"Timeout: no boot ROM write pulse in ", name});
			end
			@(negedge clk_1x);
		end
		// Bytes swapped inside each beat with the first beat on top
		compare({name, "_data"}, {data[7:0], data[15:8], data[23:16], data[31:24]},
			pifrom_wrdata);
		compare({name, "_addr"}, {idx[6], addr[10:2]}, pifrom_wraddress);
		@(negedge clk_1x);
		compare({name, "_single_pulse"}, 0, pifrom_wren);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
	endtask

	task automatic load_gb_word(string name, logic [7:0] idx, logic [26:0] addr,
		logic [31:0] data);
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= idx;
		send_beat(name, addr, data[15:0]);
		send_beat(name, addr | 27'd2, data[31:16]);
		@(negedge clk_1x);
		compare({name, "_wait_high"}, 1, ioctl_wait);
		wait_host_release(name);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		ref_write(addr + CART_BASE, 4'hF, data);
	endtask

	// ========================================
	// System port
	// ========================================

	task automatic sys_issue(logic rnw, logic [26:0] addr, logic [3:0] be,
		logic [31:0] data);
		sys_req   <= 1'b1;
		sys_rnw   <= rnw;
		sys_addr  <= addr;
		sys_be    <= be;
		sys_wdata <= data;
	endtask

	task automatic sys_access(string name, logic rnw, logic [26:0] addr, logic [3:0] be,
		logic [31:0] data, output logic [31:0] rdata);
		int cyc;
		cyc = 0;
		@(posedge clk_1x);
		sys_issue(rnw, addr, be, data);
		@(posedge clk_1x);
		sys_req <= 1'b0;
		@(negedge clk_1x);
		while (!sys_ready) begin
			cyc++;
			if (cyc > TIMEOUT) begin
				stop_on_error({"Timeout: no sys_ready in ", name});
			end
			@(negedge clk_1x);
		end
		rdata = sys_rdata;
	endtask

	// System write lands on the same edge as the cartridge request
	task automatic contend_pair(string name, logic [7:0] idx, logic [26:0] saddr,
		logic [3:0] sbe, logic [31:0] sdata, logic [26:0] gaddr, logic [31:0] gdata);
		int cyc;
		int sys_cnt;
		int cart_cnt;
		int sys_first;
		cyc       = 0;
		sys_cnt   = 0;
		cart_cnt  = 0;
		sys_first = 0;
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= idx;
		send_beat(name, gaddr, gdata[15:0]);
		send_beat(name, gaddr | 27'd2, gdata[31:16]);
		sys_issue(1'b0, saddr, sbe, sdata);
		@(posedge clk_1x);
		sys_req <= 1'b0;
		while ((sys_cnt == 0 || cart_cnt == 0) && cyc < TIMEOUT) begin
			@(negedge clk_1x);
			cyc++;
			if (sys_ready) begin
				if (cart_cnt == 0) begin
					sys_first = 1;
				end
				sys_cnt++;
			end
			if (UUT.cart_ready) begin
				cart_cnt++;
			end
		end
		if (sys_cnt == 0 || cart_cnt == 0) begin
			stop_on_error({"Timeout: a port never got its ready in ", name});
		end
		// Watch for a duplicate ready
		repeat (4) begin
			@(negedge clk_1x);
			sys_cnt  += int'(sys_ready);
			cart_cnt += int'(UUT.cart_ready);
		end
		compare({name, "_sys_readies"}, 1, sys_cnt);
		compare({name, "_cart_readies"}, 1, cart_cnt);
		compare({name, "_sys_first"}, 1, sys_first);
		wait_host_release(name);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		ref_write(saddr, sbe, sdata);
		ref_write(gaddr + CART_BASE, 4'hF, gdata);
	endtask

	// ========================================
	// ROM copy and aspect ratio
	// ========================================

	task automatic finish_n64_download(string name, logic [7:0] idx, logic [26:0] size);
		int cyc;
		cyc = 0;
		@(negedge clk_1x);
		// Only a main cartridge download may set it
		compare({name, "_not_loaded_before"}, 0, cart_loaded);
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= idx;
		ioctl_addr     <= '0;
		repeat (3) @(posedge clk_1x);
		ioctl_addr <= size;
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		@(negedge clk_1x);
		while (!romcopy_start) begin
			cyc++;
			if (cyc > TIMEOUT) begin
				stop_on_error({"Timeout: romcopy_start never pulsed in ", name});
			end
			@(negedge clk_1x);
		end
		compare({name, "_size"}, size, romcopy_size);
		repeat (4) begin
			@(negedge clk_1x);
			compare({name, "_single_pulse"}, 0, romcopy_start);
		end
		compare({name, "_cart_loaded"}, 1, cart_loaded);
	endtask

	task automatic check_aspect(string name, logic [6:0] set);
		logic [11:0] exp_x;
		logic [11:0] exp_y;
		@(posedge clk_1x);
		pal              <= set[6];
		fixed_blanks_off <= set[5];
		direct_fb        <= set[4];
		crop_vertical    <= set[3:2];
		ar_mode          <= set[1:0];
		if (set[5] || set[4]) begin
			core_x = 12'd4;
			core_y = 12'd3;
		end else if (set[6]) begin
			case (set[3:2])
				2'd0: {core_x, core_y} = {12'd512, 12'd387};
				2'd1: {core_x, core_y} = {12'd1024, 12'd731};
				2'd2: {core_x, core_y} = {12'd2048, 12'd1419};
				default: ;
			endcase
		end else begin
			case (set[3:2])
				2'd0: {core_x, core_y} = {12'd512, 12'd381};
				2'd1: {core_x, core_y} = {12'd1280, 12'd889};
				2'd2: {core_x, core_y} = {12'd2560, 12'd1714};
				default: ;
			endcase
		end
		exp_x = (set[1:0] == 2'd0) ? core_x : 12'(set[1:0] - 2'd1);
		exp_y = (set[1:0] == 2'd0) ? core_y : 12'd0;
		repeat (2) @(posedge clk_1x);
		@(negedge clk_1x);
		compare({name, "_arx"}, exp_x, video_arx);
		compare({name, "_ary"}, exp_y, video_ary);
	endtask

	task automatic build_table();
		logic [26:0] gb_a;
		logic [26:0] sa;
		logic [26:0] pa;
		logic [26:0] pb;
		gb_a = make_addr(10'h011);
		sa   = make_addr(10'h022);
		pa   = make_addr(10'h033);
		pb   = make_addr(10'h044);
		add_op(OP_PIF, "pif_idx00", 8'h00, make_addr(10'h155), 0, $urandom, 0, 0, 0);
		add_op(OP_PIF, "pif_idx40", 8'h40, make_addr(10'h2AA), 0, $urandom, 0, 0, 0);
		add_op(OP_GB, "gb_word", 8'h02, gb_a, 0, $urandom, 0, 0, 0);
		add_op(OP_SYS_RD, "gb_readback", 0, gb_a + CART_BASE, 0, 0, 0, 4'hF, 0);
		add_op(OP_SYS_WR, "sys_full", 0, sa, 0, $urandom, 0, 4'hF, 0);
		add_op(OP_SYS_WR, "sys_be_0101", 0, sa, 0, $urandom, 0, 4'b0101, 0);
		add_op(OP_SYS_WR, "sys_be_1000", 0, sa, 0, $urandom, 0, 4'b1000, 0);
		add_op(OP_SYS_RD, "sys_merged", 0, sa, 0, 0, 0, 4'hF, 0);
		// Same word index with other upper bits reads the aliased word
		add_op(OP_SYS_WR, "alias_write", 0, make_addr(10'h066), 0, $urandom, 0, 4'hF, 0);
		add_op(OP_SYS_RD, "alias_read", 0, make_addr(10'h066), 0, 0, 0, 4'hF, 0);
		add_op(OP_PAIR, "pair", 8'h02, pa, pb, $urandom, $urandom, 4'hF, 0);
		add_op(OP_SYS_RD, "pair_sys_read", 0, pa, 0, 0, 0, 4'hF, 0);
		add_op(OP_SYS_RD, "pair_gb_read", 0, pb + CART_BASE, 0, 0, 0, 4'hF, 0);
		add_op(OP_ROMCOPY, "romcopy", 8'h01, 27'($urandom), 0, 0, 0, 0, 0);
		add_op(OP_ASPECT, "ntsc_crop0", 0, 0, 0, 0, 0, 0, 7'b0_0_0_00_00);
		add_op(OP_ASPECT, "ntsc_crop1", 0, 0, 0, 0, 0, 0, 7'b0_0_0_01_00);
		add_op(OP_ASPECT, "ntsc_crop2", 0, 0, 0, 0, 0, 0, 7'b0_0_0_10_00);
		add_op(OP_ASPECT, "ntsc_crop3_hold", 0, 0, 0, 0, 0, 0, 7'b0_0_0_11_00);
		add_op(OP_ASPECT, "pal_crop0", 0, 0, 0, 0, 0, 0, 7'b1_0_0_00_00);
		add_op(OP_ASPECT, "pal_crop1", 0, 0, 0, 0, 0, 0, 7'b1_0_0_01_00);
		add_op(OP_ASPECT, "pal_crop2", 0, 0, 0, 0, 0, 0, 7'b1_0_0_10_00);
		add_op(OP_ASPECT, "fixed_blanks_off", 0, 0, 0, 0, 0, 0, 7'b1_1_0_10_00);
		add_op(OP_ASPECT, "direct_fb", 0, 0, 0, 0, 0, 0, 7'b0_0_1_01_00);
		add_op(OP_ASPECT, "ar_mode1", 0, 0, 0, 0, 0, 0, 7'b0_0_0_00_01);
		add_op(OP_ASPECT, "ar_mode2", 0, 0, 0, 0, 0, 0, 7'b0_0_0_00_10);
		add_op(OP_ASPECT, "ar_mode3", 0, 0, 0, 0, 0, 0, 7'b0_0_0_00_11);
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		logic [31:0] rdata;
		logic [26:0] addr;
		string       name;
		error_count      = 0;
		void'($urandom(7902));
		RESET            = 1'b0;
		ioctl_download   = 1'b0;
		ioctl_index      = '0;
		ioctl_addr       = '0;
		ioctl_dout       = '0;
		ioctl_wr         = 1'b0;
		sys_req          = 1'b0;
		sys_rnw          = 1'b1;
		sys_addr         = '0;
		sys_be           = '0;
		sys_wdata        = '0;
		pal              = 1'b0;
		fixed_blanks_off = 1'b0;
		direct_fb        = 1'b0;
		crop_vertical    = 2'd0;
		ar_mode          = 2'd0;
		core_x           = 12'd4;
		core_y           = 12'd3;
		build_table();
		repeat (8) @(posedge clk_1x);
		RESET <= 1'b1;
		@(negedge clk_1x);
		compare("reset_pifrom_wren", 0, pifrom_wren);
		compare("reset_ioctl_wait", 0, ioctl_wait);
		compare("reset_sys_ready", 0, sys_ready);
		compare("reset_romcopy_start", 0, romcopy_start);
		compare("reset_cart_loaded", 0, cart_loaded);
		compare("reset_arx", 4, video_arx);
		compare("reset_ary", 3, video_ary);
		for (int i = 0; i < op_kind.size(); i++) begin
			addr = op_addr[i];
			name = op_name[i];
			case (op_kind[i])
				OP_PIF: pack_pif_word(name, op_index[i], addr, op_data[i]);
				OP_GB: load_gb_word(name, op_index[i], addr, op_data[i]);
				OP_SYS_WR: begin
					sys_access(name, 1'b0, addr, op_be[i], op_data[i], rdata);
					ref_write(addr, op_be[i], op_data[i]);
				end
				OP_SYS_RD: begin
					sys_access(name, 1'b1, addr, op_be[i], '0, rdata);
					compare(name, ref_mem[addr[11:2]], rdata);
				end
				OP_PAIR: contend_pair(name, op_index[i], addr, op_be[i], op_data[i],
					op_addr2[i], op_data2[i]);
				OP_ROMCOPY: finish_n64_download(name, op_index[i], addr);
				OP_ASPECT: check_aspect(name, op_set[i]);
				default: stop_on_error({"Unknown operation kind in table entry ", name});
			endcase
		end
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* n64_dl.f */
n64_dl_pkg.sv
download_router.sv
pifrom_packer.sv
cart_writer.sv
mem_arbiter.sv
cart_ram.sv
aspect_ratio.sv
n64_dl_top.sv
tb_n64_dl.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

verilator --binary --timing -Wno-fatal --top-module tb_n64_dl -f n64_dl.f \
	-o sim_n64_dl > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_n64_dl > sim.log 2>&1
cat sim.log

grep -q 'Test failures found' sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
